/* sram_subsys.f */
source/mem_pkg.sv
source/mem_req_if.sv
source/inst_sram_port.sv
source/data_sram_port.sv
source/sram_arbiter.sv
source/sram_core.sv
source/sram_subsys.sv
test/sram_subsys_properties.sv
test/sram_subsys_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sram_subsys.f --top-module sram_subsys_tb -Mdir obj_dir

./obj_dir/Vsram_subsys_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

/* test/sram_subsys_tb.sv */
`timescale 1ns/10ps

module sram_subsys_tb;

    localparam int MEM_WORDS     = 256;
    localparam int ACCESS_CYCLES = 4;
    localparam int WB            = $clog2(MEM_WORDS);
    localparam int CLK_PERIOD    = 4;
    localparam int NUM_OPS       = 19;
    localparam int TIMEOUT_NS    = NUM_OPS * (2 * ACCESS_CYCLES + 20) * CLK_PERIOD;
    localparam int CH_IR         = 0;   // instruction read
    localparam int CH_DR         = 1;   // data read
    localparam int CH_B          = 2;   // data write response
    localparam mem_pkg::resp_t RESP_OK  = mem_pkg::RESP_OKAY;
    localparam mem_pkg::resp_t RESP_ERR = mem_pkg::RESP_SLVERR;

    typedef struct packed {
        logic           is_data;
        logic           is_write;
        logic           conc;      // instruction read of the same address alongside
        mem_pkg::addr_t addr;
        mem_pkg::data_t data;
        mem_pkg::strb_t strb;
        mem_pkg::resp_t resp;
    } op_t;

    logic           clk;
    logic           rst_n;
    mem_pkg::addr_t i_araddr;
    logic           i_arvalid;
    logic           i_arready;
    mem_pkg::data_t i_rdata;
    mem_pkg::resp_t i_rresp;
    logic           i_rvalid;
    logic           i_rready;
    mem_pkg::addr_t d_araddr;
    logic           d_arvalid;
    logic           d_arready;
    mem_pkg::data_t d_rdata;
    mem_pkg::resp_t d_rresp;
    logic           d_rvalid;
    logic           d_rready;
    mem_pkg::addr_t d_awaddr;
    logic           d_awvalid;
    logic           d_awready;
    mem_pkg::data_t d_wdata;
    mem_pkg::strb_t d_wstrb;
    logic           d_wvalid;
    logic           d_wready;
    mem_pkg::resp_t d_bresp;
    logic           d_bvalid;
    logic           d_bready;

    op_t            ops [NUM_OPS];
    int             op_count;
    mem_pkg::data_t model [MEM_WORDS];   // mirror of the SRAM contents
    logic [31:0]    rng;
    int             mismatches;
    int             protocol_errors;

    sram_subsys #(
        .MEM_WORDS     (MEM_WORDS),
        .ACCESS_CYCLES (ACCESS_CYCLES)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic in_range(input mem_pkg::addr_t addr);
        return addr < 32'(MEM_WORDS * 4);
    endfunction

    function automatic mem_pkg::data_t merge_bytes(input mem_pkg::data_t old_word,
                                                   input mem_pkg::data_t new_word,
                                                   input mem_pkg::strb_t strb);
        mem_pkg::data_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic string chan_prefix(input int ch);
        case (ch)
            CH_IR:   return "i_r";
            CH_DR:   return "d_r";
            default: return "d_b";
        endcase
    endfunction

    function automatic logic valid_of(input int ch);
        case (ch)
            CH_IR:   return i_rvalid;
            CH_DR:   return d_rvalid;
            default: return d_bvalid;
        endcase
    endfunction

    function automatic mem_pkg::data_t data_of(input int ch);
        return (ch == CH_IR) ? i_rdata : d_rdata;
    endfunction

    function automatic mem_pkg::resp_t resp_of(input int ch);
        case (ch)
            CH_IR:   return i_rresp;
            CH_DR:   return d_rresp;
            default: return d_bresp;
        endcase
    endfunction

    task automatic set_ready(input int ch, input logic val);
        case (ch)
            CH_IR:   i_rready = val;
            CH_DR:   d_rready = val;
            default: d_bready = val;
        endcase
    endtask

    task automatic check_data(input string name, input mem_pkg::data_t exp,
                              input mem_pkg::data_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input mem_pkg::resp_t exp,
                              input mem_pkg::resp_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            mismatches++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic add_op(input logic is_data, input logic is_write, input logic conc,
                          input mem_pkg::addr_t addr, input mem_pkg::data_t data,
                          input mem_pkg::strb_t strb, input mem_pkg::resp_t resp);
        ops[op_count] = '{is_data, is_write, conc, addr, data, strb, resp};
        op_count++;
    endtask

    task automatic load_table();
        op_count = 0;
        add_op(1'b1, 1'b1, 1'b0, 32'h0000_0000, 32'h0bad_f00d, 4'hf, RESP_OK);
        add_op(1'b1, 1'b1, 1'b0, 32'h0000_0010, 32'hdead_beef, 4'hf, RESP_OK);
        add_op(1'b1, 1'b0, 1'b0, 32'h0000_0010, 32'h0,         4'h0, RESP_OK);
        add_op(1'b1, 1'b1, 1'b0, 32'h0000_0010, 32'h1122_3344, 4'h5, RESP_OK);
        add_op(1'b1, 1'b0, 1'b0, 32'h0000_0010, 32'h0,         4'h0, RESP_OK);
        add_op(1'b1, 1'b1, 1'b0, 32'h0000_0024, 32'hcafe_f00d, 4'hf, RESP_OK);
        add_op(1'b1, 1'b1, 1'b0, 32'h0000_0024, 32'h00ff_00ff, 4'ha, RESP_OK);
        add_op(1'b0, 1'b0, 1'b0, 32'h0000_0024, 32'h0,         4'h0, RESP_OK);
        add_op(1'b1, 1'b1, 1'b0, 32'h0000_03fc, 32'ha5a5_5a5a, 4'hf, RESP_OK);
        add_op(1'b1, 1'b0, 1'b0, 32'h0000_03fd, 32'h0,         4'h0, RESP_OK);  // byte offset
        add_op(1'b1, 1'b0, 1'b1, 32'h0000_0010, 32'h0,         4'h0, RESP_OK);  // inst wins
        add_op(1'b0, 1'b0, 1'b0, 32'h0000_03fc, 32'h0,         4'h0, RESP_OK);
        add_op(1'b1, 1'b0, 1'b1, 32'h0000_0024, 32'h0,         4'h0, RESP_OK);  // data wins
        add_op(1'b1, 1'b1, 1'b0, 32'h0000_0400, 32'hffff_ffff, 4'hf, RESP_ERR);
        add_op(1'b1, 1'b0, 1'b0, 32'h0000_0400, 32'h0,         4'h0, RESP_ERR);
        add_op(1'b0, 1'b0, 1'b0, 32'h0000_0404, 32'h0,         4'h0, RESP_ERR);
        add_op(1'b1, 1'b1, 1'b0, 32'hffff_fffc, 32'h1234_5678, 4'hf, RESP_ERR);
        add_op(1'b1, 1'b0, 1'b0, 32'h0000_0000, 32'h0,         4'h0, RESP_OK);  // alias of 0x400
        add_op(1'b0, 1'b0, 1'b0, 32'h0000_03fc, 32'h0,         4'h0, RESP_OK);
    endtask

    // waits for valid, then accepts the response once under random stalls
    task automatic collect(input int ch, input int exp_lat, input mem_pkg::data_t exp_data,
                           input mem_pkg::resp_t exp_resp);
        int          lat;
        logic        go;
        logic [31:0] r;
        #1;
        lat = 1;
        while (!valid_of(ch)) begin
            @(negedge clk);
            #1;
            lat++;
        end
        if (exp_lat >= 0) begin
            check_latency({chan_prefix(ch), "valid latency"}, exp_lat, lat);
        end
        go = 1'b0;
        while (!go) begin
            @(negedge clk);
            r  = next_rand();
            go = (r[1:0] != 2'b00);
            set_ready(ch, go);
            #1;
            if (!valid_of(ch)) begin
                protocol_errors++;
                $display("%0t: %svalid fell before the response was taken", $time,
                         chan_prefix(ch));
            end
            if (go) begin
                if (ch != CH_B) begin
                    check_data({chan_prefix(ch), "data"}, exp_data, data_of(ch));
                end
                check_resp({chan_prefix(ch), "resp"}, exp_resp, resp_of(ch));
            end
        end
        @(negedge clk);
        set_ready(ch, 1'b0);
        #1;
        if (valid_of(ch)) begin
            protocol_errors++;
            $display("%0t: %svalid still high after the response was taken", $time,
                     chan_prefix(ch));
        end
    endtask

    task automatic inst_read(input mem_pkg::addr_t addr, input mem_pkg::data_t exp_data,
                             input mem_pkg::resp_t exp_resp, input int exp_lat);
        @(negedge clk);
        i_araddr  = addr;
        i_arvalid = 1'b1;
        #1;
        while (!i_arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);   // handshake done on the edge just passed
        i_arvalid = 1'b0;
        collect(CH_IR, exp_lat, exp_data, exp_resp);
    endtask

    task automatic data_read(input mem_pkg::addr_t addr, input mem_pkg::data_t exp_data,
                             input mem_pkg::resp_t exp_resp, input int exp_lat);
        @(negedge clk);
        d_araddr  = addr;
        d_arvalid = 1'b1;
        #1;
        while (!d_arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        d_arvalid = 1'b0;
        collect(CH_DR, exp_lat, exp_data, exp_resp);
    endtask

    task automatic data_write(input mem_pkg::addr_t addr, input mem_pkg::data_t data,
                              input mem_pkg::strb_t strb, input mem_pkg::resp_t exp_resp,
                              input int exp_lat);
        @(negedge clk);
        d_awaddr  = addr;
        d_awvalid = 1'b1;
        d_wdata   = data;
        d_wstrb   = strb;
        d_wvalid  = 1'b1;
        #1;
        while (!(d_awready && d_wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        d_awvalid = 1'b0;
        d_wvalid  = 1'b0;
        collect(CH_B, exp_lat, '0, exp_resp);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: operation table not finished after %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        op_t            op;
        mem_pkg::data_t exp;
        int             lat;
        rst_n           = 1'b0;
        i_araddr        = '0;
        i_arvalid       = 1'b0;
        i_rready        = 1'b0;
        d_araddr        = '0;
        d_arvalid       = 1'b0;
        d_rready        = 1'b0;
        d_awaddr        = '0;
        d_awvalid       = 1'b0;
        d_wdata         = '0;
        d_wstrb         = '0;
        d_wvalid        = 1'b0;
        d_bready        = 1'b0;
        rng             = 32'h82f;
        mismatches      = 0;
        protocol_errors = 0;
        load_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_bit("i_arready", 1'b1, i_arready);
        check_bit("d_arready", 1'b1, d_arready);
        check_bit("d_awready", 1'b1, d_awready);
        check_bit("d_wready", 1'b1, d_wready);
        check_bit("i_rvalid", 1'b0, i_rvalid);
        check_bit("d_rvalid", 1'b0, d_rvalid);
        check_bit("d_bvalid", 1'b0, d_bvalid);

        for (int n = 0; n < NUM_OPS; n++) begin
            op  = ops[n];
            // latency only fixed without contention
            lat = op.conc ? -1 : ((op.resp == RESP_OK) ? ACCESS_CYCLES + 2 : 2);
            if (op.is_write) begin
                if (in_range(op.addr)) begin
                    model[op.addr[WB+1:2]] = merge_bytes(model[op.addr[WB+1:2]], op.data,
                                                         op.strb);
                end
                data_write(op.addr, op.data, op.strb, op.resp, lat);
            end else begin
                exp = in_range(op.addr) ? model[op.addr[WB+1:2]] : '0;
                if (!op.is_data) begin
                    inst_read(op.addr, exp, op.resp, lat);
                end else if (op.conc) begin
                    fork
                        inst_read(op.addr, exp, op.resp, -1);
                        data_read(op.addr, exp, op.resp, -1);
                    join
                end else begin
                    data_read(op.addr, exp, op.resp, lat);
                end
            end
        end

        $display("mismatches: %0d, protocol errors: %0d", mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* test/sram_subsys_properties.sv */
`timescale 1ns/10ps

module sram_subsys_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        first_req,
    input logic        first_ack,
    input logic        second_req,
    input logic        second_ack,
    input logic        ch0_valid,
    input logic        ch0_ready,
    input logic [33:0] ch0_payload,   // {resp, data}
    input logic        ch1_valid,
    input logic        ch1_ready,
    input logic [33:0] ch1_payload
);

    a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(first_ack && second_ack))
        else $error("ack returned to both requesters in one cycle");

    a_first_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        first_ack |-> first_req)
        else $error("ack on first link without a pending req");

    a_second_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        second_ack |-> second_req)
        else $error("ack on second link without a pending req");

    // response held under back-pressure
    a_ch0_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ch0_valid && !ch0_ready |=> ch0_valid && $stable(ch0_payload))
        else $error("channel 0 response dropped or changed while stalled");

    a_ch1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ch1_valid && !ch1_ready |=> ch1_valid && $stable(ch1_payload))
        else $error("channel 1 response dropped or changed while stalled");

endmodule

bind sram_arbiter sram_subsys_properties u_arb_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .first_req   (inst.req),
    .first_ack   (inst.ack),
    .second_req  (data.req),
    .second_ack  (data.ack),
    .ch0_valid   (1'b0),
    .ch0_ready   (1'b0),
    .ch0_payload (34'h0),
    .ch1_valid   (1'b0),
    .ch1_ready   (1'b0),
    .ch1_payload (34'h0)
);

bind inst_sram_port sram_subsys_properties u_inst_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .first_req   (mem.req),
    .first_ack   (mem.ack),
    .second_req  (1'b0),
    .second_ack  (1'b0),
    .ch0_valid   (rvalid),
    .ch0_ready   (rready),
    .ch0_payload ({rresp, rdata}),
    .ch1_valid   (1'b0),
    .ch1_ready   (1'b0),
    .ch1_payload (34'h0)
);

bind data_sram_port sram_subsys_properties u_data_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .first_req   (mem.req),
    .first_ack   (mem.ack),
    .second_req  (1'b0),
    .second_ack  (1'b0),
    .ch0_valid   (rvalid),
    .ch0_ready   (rready),
    .ch0_payload ({rresp, rdata}),
    .ch1_valid   (bvalid),
    .ch1_ready   (bready),
    .ch1_payload ({bresp, 32'h0})
);

/* source/sram_subsys.sv */
`timescale 1ns/10ps

module sram_subsys #(
    parameter int MEM_WORDS     = 256,
    parameter int ACCESS_CYCLES = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    // instruction port, read only
    input  mem_pkg::addr_t i_araddr,
    input  logic           i_arvalid,
    output logic           i_arready,
    output mem_pkg::data_t i_rdata,
    output mem_pkg::resp_t i_rresp,
    output logic           i_rvalid,
    input  logic           i_rready,
    // data port
    input  mem_pkg::addr_t d_araddr,
    input  logic           d_arvalid,
    output logic           d_arready,
    output mem_pkg::data_t d_rdata,
    output mem_pkg::resp_t d_rresp,
    output logic           d_rvalid,
    input  logic           d_rready,
    input  mem_pkg::addr_t d_awaddr,
    input  logic           d_awvalid,
    output logic           d_awready,
    input  mem_pkg::data_t d_wdata,
    input  mem_pkg::strb_t d_wstrb,
    input  logic           d_wvalid,
    output logic           d_wready,
    output mem_pkg::resp_t d_bresp,
    output logic           d_bvalid,
    input  logic           d_bready
);

    mem_req_if #(.MEM_WORDS(MEM_WORDS)) inst_req ();
    mem_req_if #(.MEM_WORDS(MEM_WORDS)) data_req ();
    mem_req_if #(.MEM_WORDS(MEM_WORDS)) core_req ();

    inst_sram_port #(.MEM_WORDS(MEM_WORDS)) u_inst_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (i_araddr),
        .arvalid (i_arvalid),
        .arready (i_arready),
        .rdata   (i_rdata),
        .rresp   (i_rresp),
        .rvalid  (i_rvalid),
        .rready  (i_rready),
        .mem     (inst_req.requester)
    );

    data_sram_port #(.MEM_WORDS(MEM_WORDS)) u_data_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (d_araddr),
        .arvalid (d_arvalid),
        .arready (d_arready),
        .rdata   (d_rdata),
        .rresp   (d_rresp),
        .rvalid  (d_rvalid),
        .rready  (d_rready),
        .awaddr  (d_awaddr),
        .awvalid (d_awvalid),
        .awready (d_awready),
        .wdata   (d_wdata),
        .wstrb   (d_wstrb),
        .wvalid  (d_wvalid),
        .wready  (d_wready),
        .bresp   (d_bresp),
        .bvalid  (d_bvalid),
        .bready  (d_bready),
        .mem     (data_req.requester)
    );

    sram_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .inst  (inst_req.responder),
        .data  (data_req.responder),
        .mem   (core_req.requester)
    );

    sram_core #(
        .MEM_WORDS     (MEM_WORDS),
        .ACCESS_CYCLES (ACCESS_CYCLES)
    ) u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (core_req.responder)
    );

endmodule

/* source/sram_core.sv */
`timescale 1ns/10ps

module sram_core #(
    parameter int MEM_WORDS     = 256,
    parameter int ACCESS_CYCLES = 4
) (
    input logic          clk,
    input logic          rst_n,
    mem_req_if.responder mem
);

    localparam int CW = $clog2(ACCESS_CYCLES + 1);

    mem_pkg::data_t mem_array [MEM_WORDS];
    logic           busy;
    logic [CW-1:0]  cnt;   // cycles left until the access

    assign mem.ack   = busy && (cnt == '0);
    assign mem.rdata = mem_array[mem.addr];   // requester holds addr until ack

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (!busy) begin
            if (mem.req) begin
                busy <= 1'b1;
                cnt  <= CW'(ACCESS_CYCLES - 1);
            end
        end else if (cnt == '0) begin
            busy <= 1'b0;
        end else begin
            cnt <= cnt - CW'(1);
        end
    end

    // byte lanes written only where strb is set
    always_ff @(posedge clk) begin
        if (mem.ack && mem.we) begin
            for (int i = 0; i < 4; i++) begin
                if (mem.strb[i]) begin
                    mem_array[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* source/sram_arbiter.sv */
`timescale 1ns/10ps

module sram_arbiter (
    input logic          clk,
    input logic          rst_n,
    mem_req_if.responder inst,
    mem_req_if.responder data,
    mem_req_if.requester mem
);

    logic busy;    // core access in progress
    logic owner;   // 1 = data port
    logic last;    // previous winner
    logic sel;

    // grant is combinational, locked to owner until ack
    always_comb begin
        if (busy) begin
            sel = owner;
        end else if (inst.req && data.req) begin
            sel = !last;   // round robin on a tie
        end else begin
            sel = data.req;
        end
    end

    assign mem.req   = sel ? data.req   : inst.req;
    assign mem.we    = sel ? data.we    : inst.we;
    assign mem.addr  = sel ? data.addr  : inst.addr;
    assign mem.wdata = sel ? data.wdata : inst.wdata;
    assign mem.strb  = sel ? data.strb  : inst.strb;

    assign inst.ack   = mem.ack && !sel;
    assign data.ack   = mem.ack && sel;
    assign inst.rdata = sel ? '0 : mem.rdata;
    assign data.rdata = sel ? mem.rdata : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            last  <= 1'b1;   // first tie goes to instruction fetch
        end else if (mem.ack) begin
            busy <= 1'b0;
            last <= sel;
        end else if (!busy && mem.req) begin
            busy  <= 1'b1;
            owner <= sel;
        end
    end

endmodule

/* source/data_sram_port.sv */
`timescale 1ns/10ps

module data_sram_port #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rst_n,
    input  mem_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output mem_pkg::data_t rdata,
    output mem_pkg::resp_t rresp,
    output logic           rvalid,
    input  logic           rready,
    input  mem_pkg::addr_t awaddr,
    input  logic           awvalid,
    output logic           awready,
    input  mem_pkg::data_t wdata,
    input  mem_pkg::strb_t wstrb,
    input  logic           wvalid,
    output logic           wready,
    output mem_pkg::resp_t bresp,
    output logic           bvalid,
    input  logic           bready,
    mem_req_if.requester   mem
);

    localparam int AW = mem_pkg::word_bits(MEM_WORDS);

    mem_pkg::port_state_t state;
    logic                 we_q;     // current transaction is a write
    logic [AW-1:0]        addr_q;
    mem_pkg::data_t       wdata_q;
    mem_pkg::strb_t       strb_q;
    mem_pkg::resp_t       resp_q;
    logic                 idle;
    logic                 ar_hs;
    logic                 wr_hs;
    logic                 rd_ok;
    logic                 wr_ok;

    assign idle  = (state == mem_pkg::ST_IDLE);
    assign rd_ok = araddr[31:2] < 30'(MEM_WORDS);
    assign wr_ok = awaddr[31:2] < 30'(MEM_WORDS);

    // reads win; AW and W only ever complete together
    assign arready = idle;
    assign awready = idle && !arvalid && (wvalid || !awvalid);
    assign wready  = idle && !arvalid && (awvalid || !wvalid);

    assign ar_hs = arvalid && arready;
    assign wr_hs = awvalid && awready && wvalid && wready;

    assign mem.req   = (state == mem_pkg::ST_ISSUE) || (state == mem_pkg::ST_WAIT);
    assign mem.we    = we_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;
    assign mem.strb  = strb_q;

    assign rresp = resp_q;
    assign bresp = resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= mem_pkg::ST_IDLE;
            we_q   <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            case (state)
                mem_pkg::ST_IDLE: begin
                    if (ar_hs) begin
                        we_q  <= 1'b0;
                        state <= rd_ok ? mem_pkg::ST_ISSUE : mem_pkg::ST_RESP;
                    end else if (wr_hs) begin
                        we_q  <= 1'b1;
                        state <= wr_ok ? mem_pkg::ST_ISSUE : mem_pkg::ST_RESP;
                    end
                end
                mem_pkg::ST_ISSUE: begin
                    state <= mem_pkg::ST_WAIT;
                end
                mem_pkg::ST_WAIT: begin
                    if (mem.ack) begin
                        state  <= mem_pkg::ST_RESP;
                        bvalid <= we_q;
                        rvalid <= !we_q;
                    end
                end
                mem_pkg::ST_RESP: begin
                    if (we_q) begin
                        if (!bvalid) begin
                            bvalid <= 1'b1;   // error path, no ack seen
                        end else if (bready) begin
                            bvalid <= 1'b0;
                            state  <= mem_pkg::ST_IDLE;
                        end
                    end else if (!rvalid) begin
                        rvalid <= 1'b1;
                    end else if (rready) begin
                        rvalid <= 1'b0;
                        state  <= mem_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= mem_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr[AW+1:2];
            resp_q <= rd_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
            rdata  <= '0;
        end else if (wr_hs) begin
            addr_q  <= awaddr[AW+1:2];
            wdata_q <= wdata;
            strb_q  <= wstrb;
            resp_q  <= wr_ok ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
        end else if ((state == mem_pkg::ST_WAIT) && mem.ack && !we_q) begin
            rdata <= mem.rdata;
        end
    end

endmodule

/* source/inst_sram_port.sv */
`timescale 1ns/10ps

module inst_sram_port #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rst_n,
    input  mem_pkg::addr_t araddr,
    input  logic           arvalid,
    output logic           arready,
    output mem_pkg::data_t rdata,
    output mem_pkg::resp_t rresp,
    output logic           rvalid,
    input  logic           rready,
    mem_req_if.requester   mem
);

    localparam int AW = mem_pkg::word_bits(MEM_WORDS);

    mem_pkg::port_state_t state;
    logic [AW-1:0]        addr_q;
    logic                 ar_hs;
    logic                 in_range;

    assign ar_hs    = arvalid && arready;
    assign in_range = araddr[31:2] < 30'(MEM_WORDS);   // byte offset ignored
    assign arready  = (state == mem_pkg::ST_IDLE);

    // fetch only, write fields tied off
    assign mem.req   = (state == mem_pkg::ST_ISSUE) || (state == mem_pkg::ST_WAIT);
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.strb  = '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= mem_pkg::ST_IDLE;
            rvalid <= 1'b0;
        end else begin
            case (state)
                mem_pkg::ST_IDLE: begin
                    if (ar_hs) begin
                        state <= in_range ? mem_pkg::ST_ISSUE : mem_pkg::ST_RESP;
                    end
                end
                mem_pkg::ST_ISSUE: begin
                    state <= mem_pkg::ST_WAIT;   // req already visible to arbiter
                end
                mem_pkg::ST_WAIT: begin
                    if (mem.ack) begin
                        state  <= mem_pkg::ST_RESP;
                        rvalid <= 1'b1;
                    end
                end
                mem_pkg::ST_RESP: begin
                    if (!rvalid) begin
                        rvalid <= 1'b1;   // out-of-range read lands here
                    end else if (rready) begin
                        rvalid <= 1'b0;
                        state  <= mem_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= mem_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr[AW+1:2];
            rresp  <= in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
            rdata  <= '0;   // stays zero on SLVERR
        end else if ((state == mem_pkg::ST_WAIT) && mem.ack) begin
            rdata <= mem.rdata;
        end
    end

endmodule

/* source/mem_req_if.sv */
`timescale 1ns/10ps

interface mem_req_if #(
    parameter int MEM_WORDS = 256
);

    localparam int AW = mem_pkg::word_bits(MEM_WORDS);

    logic           req;
    logic           we;
    logic [AW-1:0]  addr;    // word index, not byte address
    mem_pkg::data_t wdata;
    mem_pkg::strb_t strb;
    logic           ack;     // one-cycle pulse
    mem_pkg::data_t rdata;   // valid together with ack

    modport requester (
        output req, we, addr, wdata, strb,
        input  ack, rdata
    );

    modport responder (
        input  req, we, addr, wdata, strb,
        output ack, rdata
    );

endinterface

/* source/mem_pkg.sv */
package mem_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;   // one enable per byte lane
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // slave port FSM, same shape for both ports
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_RESP
    } port_state_t;

    // width of a word index into a memory of the given depth
    function automatic int word_bits(input int words);
        return (words > 1) ? $clog2(words) : 1;
    endfunction

endpackage
